//--- flist.f
+incdir+include
src/lnorm_pkg.sv
src/lnorm_stats.sv
src/lnorm_sqrt.sv
src/lnorm_scale.sv
src/layer_norm.sv
verif/layer_norm_tb.sv

//--- Makefile
TOP = layer_norm_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/layer_norm_tb.sv
`default_nettype none

`include "lnorm_macros.svh"

module layer_norm_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int W           = `LN_WIDTH;
    localparam int F           = `LN_FRAC;
    localparam int DEPTH       = `LN_DEPTH;
    localparam int RANDOM_RUNS = 40;
    // Flat vector, two saturating vectors and the busy strobe run
    localparam int NUM_RUNS    = RANDOM_RUNS + 4;
    // Capture, stats, gap, root, gap, scale
    localparam int LATENCY     = 1 + 4 + 1 + (`LN_SQRT_ITER + 1) + 1 + 3;
    localparam int TIMEOUT_NS  = (NUM_RUNS * 30 + 100) * 4;

    typedef logic signed [W-1:0] vec_t [DEPTH-1:0];

    logic        clk;
    logic        reset;
    logic        in_valid;
    vec_t        data_in;
    vec_t        gamma_in;
    vec_t        beta_in;
    logic        busy;
    logic        out_valid;
    vec_t        data_out;

    vec_t        exp_out;
    logic        started;
    logic        pending;
    int          lat_cnt;
    int          accept_count;
    int          result_count;
    int          value_errors;
    int          protocol_errors;
    logic [31:0] lfsr_state;

    layer_norm UUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .data_in   (data_in),
        .gamma_in  (gamma_in),
        .beta_in   (beta_in),
        .busy      (busy),
        .out_valid (out_valid),
        .data_out  (data_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int saturate(input int v);
        if (v > (2 ** (W - 1)) - 1)
            return (2 ** (W - 1)) - 1;
        else if (v < -(2 ** (W - 1)))
            return -(2 ** (W - 1));
        return v;
    endfunction

    // Mean by arithmetic shift of the sum
    function automatic int vector_mean(input vec_t x);
        int sum;
        sum = 0;
        for (int i = 0; i < DEPTH; i++)
            sum += x[i];
        return sum >>> `LN_LOG_DEPTH;
    endfunction

    // Floor of the root of the variance, capped to W-1 magnitude bits
    function automatic int vector_std(input vec_t x, input int mean);
        int sq_sum;
        int var_v;
        int r;
        sq_sum = 0;
        r = 0;
        for (int i = 0; i < DEPTH; i++)
            sq_sum += (x[i] - mean) * (x[i] - mean);
        var_v = sq_sum >> `LN_LOG_DEPTH;
        while ((r + 1) * (r + 1) <= var_v)
            r++;
        return (r > (2 ** (W - 1)) - 1) ? (2 ** (W - 1)) - 1 : r;
    endfunction

    function automatic int norm_element(input int d, input int std_dev, input int g,
                                        input int b);
        int q;
        int p;
        q = saturate((d * (1 << F)) / (std_dev + 1));
        p = (q * g) >>> F;
        return saturate(p + b);
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        value_errors++;
        $display("error t=%0t %s expected %0d got %0d", $time, name, expected, actual);
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic draw_word(output logic signed [W-1:0] word);
        for (int b = 0; b < W; b++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            word[b] = lfsr_state[0];
        end
    endtask

    task automatic fill_random;
        for (int i = 0; i < DEPTH; i++)
        begin
            draw_word(data_in[i]);
            draw_word(gamma_in[i]);
            draw_word(beta_in[i]);
        end
    endtask

    task automatic fill_flat;
        logic signed [W-1:0] level;
        draw_word(level);
        for (int i = 0; i < DEPTH; i++)
        begin
            data_in[i] = level;
            draw_word(gamma_in[i]);
            draw_word(beta_in[i]);
        end
    endtask

    // Full-scale samples with maximum gamma and beta pushing the same way
    task automatic fill_extreme(input bit halves);
        logic high;
        for (int i = 0; i < DEPTH; i++)
        begin
            high = halves ? (i >= DEPTH / 2) : i[0];
            data_in[i] = high ? W'((2 ** (W - 1)) - 1) : W'(-(2 ** (W - 1)));
            gamma_in[i] = W'((2 ** (W - 1)) - 1);
            beta_in[i] = high ? W'(120) : W'(-120);
        end
    endtask

    task automatic strobe;
        started = 1'b1;
        in_valid = 1'b1;
        next_cycle;
        in_valid = 1'b0;
    endtask

    task automatic wait_result;
        while (!out_valid)
            next_cycle;
    endtask

    // Reference result taken from the vectors on the accepting edge
    always @(posedge clk)
    begin
        int mean_v;
        int std_v;
        if (reset)
        begin
            pending <= 1'b0;
            lat_cnt <= 0;
        end
        else
        begin
            if (out_valid)
            begin
                pending <= 1'b0;
                result_count <= result_count + 1;
            end
            if (in_valid && !busy)
            begin
                mean_v = vector_mean(data_in);
                std_v = vector_std(data_in, mean_v);
                for (int i = 0; i < DEPTH; i++)
                    exp_out[i] <= W'(norm_element(data_in[i] - mean_v, std_v,
                                                  gamma_in[i], beta_in[i]));
                pending <= 1'b1;
                lat_cnt <= 0;
                accept_count <= accept_count + 1;
            end
            else if (pending)
                lat_cnt <= lat_cnt + 1;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !started |-> !busy)
    else report_mismatch("busy", 0, $sampled(busy));

    assert property (@(posedge clk) disable iff (reset) !started |-> !out_valid)
    else report_mismatch("out_valid", 0, $sampled(out_valid));

    for (genvar i = 0; i < DEPTH; i++)
    begin : check_lane
        assert property (@(posedge clk) disable iff (reset)
            out_valid |-> data_out[i] == exp_out[i])
        else report_mismatch($sformatf("data_out[%0d]", i), $sampled(exp_out[i]),
                             $sampled(data_out[i]));
    end

    assert property (@(posedge clk) disable iff (reset) out_valid |-> pending)
    else
    begin
        protocol_errors++;
        $display("out_valid pulsed at %0t with no accepted vector waiting", $time);
    end

    // out_valid is set on the LATENCY-th edge and seen on the sample after it
    assert property (@(posedge clk) disable iff (reset) out_valid |-> lat_cnt == LATENCY)
    else report_mismatch("out_valid latency", LATENCY, $sampled(lat_cnt));

    assert property (@(posedge clk) disable iff (reset) out_valid |-> !busy && $past(busy))
    else
    begin
        protocol_errors++;
        $display("busy did not fall together with out_valid at %0t", $time);
    end

    initial
    begin
        lnorm_pkg::ln_state_t stuck_state;
        #(TIMEOUT_NS);
        stuck_state = UUT.state;
        $display("Run timed out at %0t with the DUT in state %s", $time, stuck_state.name());
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        reset = 1'b1;
        in_valid = 1'b0;
        started = 1'b0;
        accept_count = 0;
        result_count = 0;
        value_errors = 0;
        protocol_errors = 0;
        lfsr_state = 32'hb00c_0a5e;
        for (int i = 0; i < DEPTH; i++)
        begin
            data_in[i] = '0;
            gamma_in[i] = '0;
            beta_in[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (5) next_cycle;

        for (int n = 0; n < RANDOM_RUNS; n++)
        begin
            fill_random();
            strobe();
            wait_result();
        end

        fill_flat();
        strobe();
        wait_result();

        fill_extreme(1'b0);
        strobe();
        wait_result();
        fill_extreme(1'b1);
        strobe();
        wait_result();

        // Second strobe lands mid-run and must be dropped
        fill_random();
        strobe();
        repeat (5) next_cycle;
        fill_random();
        strobe();
        wait_result();
        repeat (LATENCY + 5) next_cycle;

        assert (result_count == accept_count)
        else
        begin
            protocol_errors++;
            $display("%0d vectors were accepted but %0d results came out",
                     accept_count, result_count);
        end

        $display("Checks done with %0d value errors and %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/layer_norm.sv
`default_nettype none

`include "lnorm_macros.svh"

module layer_norm (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_valid,
    input  logic signed [`LN_WIDTH-1:0]  data_in [`LN_DEPTH-1:0],
    input  logic signed [`LN_WIDTH-1:0]  gamma_in [`LN_DEPTH-1:0],
    input  logic signed [`LN_WIDTH-1:0]  beta_in [`LN_DEPTH-1:0],
    output logic                         busy,
    output logic                         out_valid,
    output logic signed [`LN_WIDTH-1:0]  data_out [`LN_DEPTH-1:0]
);

    localparam int W  = `LN_WIDTH;
    localparam int VW = `LN_VAR_WIDTH;

    lnorm_pkg::ln_state_t state;
    logic                 accept;

    // Vectors held from capture until the result is out
    logic signed [W-1:0]  data_q [`LN_DEPTH-1:0];
    logic signed [W-1:0]  gamma_q [`LN_DEPTH-1:0];
    logic signed [W-1:0]  beta_q [`LN_DEPTH-1:0];

    logic                 stats_start;
    logic                 stats_done;
    logic                 root_start;
    logic                 root_done;
    logic                 scale_start;
    logic                 scale_done;
    logic signed [W:0]    diff [`LN_DEPTH-1:0];
    logic [VW-1:0]        variance;
    logic [W-1:0]         std_dev;
    logic signed [W-1:0]  result [`LN_DEPTH-1:0];

    // DONE is not busy so a new vector can follow the result directly
    assign busy = (state == lnorm_pkg::STATS) || (state == lnorm_pkg::ROOT) ||
                  (state == lnorm_pkg::SCALE);
    assign accept = in_valid && !busy;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= lnorm_pkg::IDLE;
            stats_start <= 1'b0;
            root_start <= 1'b0;
            scale_start <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            stats_start <= 1'b0;
            root_start <= 1'b0;
            scale_start <= 1'b0;
            out_valid <= 1'b0;
            case (state)
                lnorm_pkg::STATS:
                begin
                    if (stats_done)
                    begin
                        state <= lnorm_pkg::ROOT;
                        root_start <= 1'b1;
                    end
                end
                lnorm_pkg::ROOT:
                begin
                    if (root_done)
                    begin
                        state <= lnorm_pkg::SCALE;
                        scale_start <= 1'b1;
                    end
                end
                lnorm_pkg::SCALE:
                begin
                    if (scale_done)
                    begin
                        state <= lnorm_pkg::DONE;
                        out_valid <= 1'b1;
                    end
                end
                default:
                begin
                    if (accept)
                    begin
                        state <= lnorm_pkg::STATS;
                        stats_start <= 1'b1;
                    end
                    else
                        state <= lnorm_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            data_q <= data_in;
            gamma_q <= gamma_in;
            beta_q <= beta_in;
        end
        if (state == lnorm_pkg::SCALE && scale_done)
            data_out <= result;
    end

    lnorm_stats u_stats (
        .clk         (clk),
        .reset       (reset),
        .stats_start (stats_start),
        .samples     (data_q),
        .diff        (diff),
        .variance    (variance),
        .stats_done  (stats_done)
    );

    lnorm_sqrt u_sqrt (
        .clk        (clk),
        .reset      (reset),
        .root_start (root_start),
        .variance   (variance),
        .std_dev    (std_dev),
        .root_done  (root_done)
    );

    lnorm_scale u_scale (
        .clk         (clk),
        .reset       (reset),
        .scale_start (scale_start),
        .diff        (diff),
        .std_dev     (std_dev),
        .gamma       (gamma_q),
        .beta        (beta_q),
        .result      (result),
        .scale_done  (scale_done)
    );

    assert property (@(posedge clk) disable iff (reset) out_valid |=> !out_valid);

    // A strobe during a run must not disturb the sequence
    assert property (@(posedge clk) disable iff (reset)
        in_valid && busy && !stats_done && !root_done && !scale_done |=> $stable(state));

endmodule

`default_nettype wire

//--- src/lnorm_scale.sv
`default_nettype none

`include "lnorm_macros.svh"

module lnorm_scale (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         scale_start,
    input  logic signed [`LN_WIDTH:0]    diff [`LN_DEPTH-1:0],
    input  logic        [`LN_WIDTH-1:0]  std_dev,
    input  logic signed [`LN_WIDTH-1:0]  gamma [`LN_DEPTH-1:0],
    input  logic signed [`LN_WIDTH-1:0]  beta [`LN_DEPTH-1:0],
    output logic signed [`LN_WIDTH-1:0]  result [`LN_DEPTH-1:0],
    output logic                         scale_done
);

    localparam int W  = `LN_WIDTH;
    localparam int F  = `LN_FRAC;
    localparam int NW = `LN_WIDTH + 1 + `LN_FRAC;
    localparam int PW = 2 * `LN_WIDTH;

    logic signed [W+1:0]  divisor;
    logic signed [NW-1:0] num [`LN_DEPTH-1:0];
    logic signed [NW-1:0] quot [`LN_DEPTH-1:0];
    logic signed [W-1:0]  div_q [`LN_DEPTH-1:0];
    logic signed [PW-1:0] mul_q [`LN_DEPTH-1:0];
    logic                 div_valid;
    logic                 mul_valid;

    always_comb
    begin
        // One LSB keeps a flat vector from dividing by zero
        divisor = $signed({2'b00, std_dev}) + 1;
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            num[i] = NW'(diff[i]) <<< F;
            // Signed divide truncates toward zero
            quot[i] = num[i] / divisor;
        end
    end

    // Stage registers load only when their input stage holds an item
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            if (scale_start)
                div_q[i] <= lnorm_pkg::sat_width(quot[i]);
            if (div_valid)
                mul_q[i] <= (div_q[i] * gamma[i]) >>> F;
            if (mul_valid)
                result[i] <= lnorm_pkg::sat_width(mul_q[i] + beta[i]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_valid <= 1'b0;
            mul_valid <= 1'b0;
            scale_done <= 1'b0;
        end
        else
        begin
            div_valid <= scale_start;
            mul_valid <= div_valid;
            scale_done <= mul_valid;
        end
    end

    assert property (@(posedge clk) disable iff (reset) scale_start |-> divisor != '0);

endmodule

`default_nettype wire

//--- src/lnorm_sqrt.sv
`default_nettype none

`include "lnorm_macros.svh"

module lnorm_sqrt (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       root_start,
    input  logic [`LN_VAR_WIDTH-1:0]   variance,
    output logic [`LN_WIDTH-1:0]       std_dev,
    output logic                       root_done
);

    localparam int W    = `LN_WIDTH;
    localparam int VW   = `LN_VAR_WIDTH;
    localparam int ITER = `LN_SQRT_ITER;
    localparam int RW   = ITER + 2;
    localparam int CW   = $clog2(ITER + 1);

    logic [2*ITER-1:0] rad_q;
    logic [ITER-1:0]   rem_q;
    logic [ITER-1:0]   root_q;
    logic [CW-1:0]     iter_cnt;
    logic              over_q;
    logic [RW-1:0]     rem_shift;
    logic [RW-1:0]     trial;
    logic              fits;
    logic [ITER-1:0]   rem_next;
    logic [ITER-1:0]   root_next;

    // One restoring step per cycle
    always_comb
    begin
        // Bring down the next two radicand bits
        rem_shift = {rem_q, rad_q[2*ITER-1 -: 2]};
        trial = {root_q, 2'b01};
        fits = rem_shift >= trial;
        rem_next = ITER'(fits ? rem_shift - trial : rem_shift);
        root_next = {root_q[ITER-2:0], fits};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            iter_cnt <= '0;
            root_done <= 1'b0;
        end
        else
        begin
            root_done <= 1'b0;
            if (root_start)
                iter_cnt <= CW'(ITER);
            else if (iter_cnt != '0)
            begin
                iter_cnt <= iter_cnt - 1'b1;
                root_done <= iter_cnt == CW'(1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (root_start)
        begin
            rad_q <= variance[2*ITER-1:0];
            rem_q <= '0;
            root_q <= '0;
            // Any bit above the radicand window means the root cannot fit
            over_q <= |variance[VW-1:2*ITER];
        end
        else if (iter_cnt != '0)
        begin
            rad_q <= rad_q << 2;
            rem_q <= rem_next;
            root_q <= root_next;
            if (iter_cnt == CW'(1))
            begin
                if (over_q)
                    std_dev <= {1'b0, {(W-1){1'b1}}};
                else
                    std_dev <= lnorm_pkg::sat_width({1'b0, root_next});
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) root_start |-> iter_cnt == '0);

endmodule

`default_nettype wire

//--- src/lnorm_stats.sv
`default_nettype none

`include "lnorm_macros.svh"

module lnorm_stats (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            stats_start,
    input  logic signed [`LN_WIDTH-1:0]     samples [`LN_DEPTH-1:0],
    output logic signed [`LN_WIDTH:0]       diff [`LN_DEPTH-1:0],
    output logic        [`LN_VAR_WIDTH-1:0] variance,
    output logic                            stats_done
);

    localparam int W   = `LN_WIDTH;
    localparam int DW  = `LN_WIDTH + 1;
    localparam int SW  = `LN_SUM_WIDTH;
    localparam int VW  = `LN_VAR_WIDTH;
    localparam int LOG = `LN_LOG_DEPTH;

    // 0 when idle, then 1 mean, 2 differences, 3 variance
    logic [2:0]             step;
    logic signed [SW-1:0]   sum_next;
    logic signed [SW-1:0]   sum_q;
    logic signed [W-1:0]    mean_q;
    logic signed [DW-1:0]   diff_next [`LN_DEPTH-1:0];
    logic signed [2*DW-1:0] sq_next [`LN_DEPTH-1:0];
    logic        [2*DW-1:0] sq_q [`LN_DEPTH-1:0];
    logic        [VW-1:0]   sq_sum;

    always_comb
    begin
        sum_next = '0;
        sq_sum = '0;
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            sum_next = sum_next + SW'(samples[i]);
            diff_next[i] = DW'(samples[i]) - DW'(mean_q);
            sq_next[i] = diff_next[i] * diff_next[i];
            sq_sum = sq_sum + VW'(sq_q[i]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            step <= '0;
            stats_done <= 1'b0;
        end
        else
        begin
            stats_done <= 1'b0;
            if (stats_start)
                step <= 3'd1;
            else if (step == 3'd3)
            begin
                step <= '0;
                stats_done <= 1'b1;
            end
            else if (step != '0)
                step <= step + 3'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (stats_start)
            sum_q <= sum_next;
        // Mean keeps the sample format after the divide by depth
        if (step == 3'd1)
            mean_q <= W'(sum_q >>> LOG);
        if (step == 3'd2)
        begin
            for (int i = 0; i < `LN_DEPTH; i++)
            begin
                diff[i] <= diff_next[i];
                sq_q[i] <= sq_next[i];
            end
        end
        if (step == 3'd3)
            variance <= sq_sum >> LOG;
    end

    // The top only relaunches once stats_done has been seen
    assert property (@(posedge clk) disable iff (reset) stats_start |-> step == '0);

endmodule

`default_nettype wire

//--- src/lnorm_pkg.sv
`default_nettype none

`include "lnorm_macros.svh"

package lnorm_pkg;

    // Sequencer states of the top level
    typedef enum logic [2:0] {
        IDLE,
        STATS,
        ROOT,
        SCALE,
        DONE
    } ln_state_t;

    localparam int SAT_IN_WIDTH = 32;

    // Clamp a wide signed value into LN_WIDTH bits
    function automatic logic signed [`LN_WIDTH-1:0] sat_width(
        input logic signed [SAT_IN_WIDTH-1:0] value
    );
        logic signed [SAT_IN_WIDTH-1:0] max_val;
        logic signed [SAT_IN_WIDTH-1:0] min_val;
        max_val = (2 ** (`LN_WIDTH - 1)) - 1;
        min_val = -(2 ** (`LN_WIDTH - 1));
        if (value > max_val)
            return max_val[`LN_WIDTH-1:0];
        else if (value < min_val)
            return min_val[`LN_WIDTH-1:0];
        else
            return value[`LN_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

//--- include/lnorm_macros.svh
`ifndef LNORM_MACROS_SVH
`define LNORM_MACROS_SVH

// Vector shape and fixed-point format
`define LN_DEPTH 8
`define LN_WIDTH 8
`define LN_FRAC 4

// Depth is a power of two so the mean and the variance divide by shift
`define LN_LOG_DEPTH $clog2(`LN_DEPTH)

// Sum of widened samples ahead of the mean shift
`define LN_SUM_WIDTH (`LN_WIDTH + `LN_LOG_DEPTH)

// Sum of squared differences of LN_WIDTH+1 bits each
`define LN_VAR_WIDTH (2 * (`LN_WIDTH + 1) + `LN_LOG_DEPTH)

// Once divided by the depth the variance fits in 2*(LN_WIDTH+1) bits
// so the root needs one iteration per pair of those bits
`define LN_SQRT_ITER ((`LN_VAR_WIDTH - `LN_LOG_DEPTH + 1) / 2)

`endif
